// File: dv/rayDispatchTb.sv
`timescale 1ns/10ps
`default_nettype none

module rayDispatchTb
    import rayPkg::*;
();

    localparam int clkPeriod = 4;
    localparam int resetCycles = 5;
    localparam int burstRays = 20;
    localparam int totalRays = burstRays + 1;
    localparam int cyclesPerRay = 3 * wordsPerRay;
    localparam int readCycles = 2 * numSlots * (wordsPerRay + 1);
    localparam int watchdogCycles = totalRays * cyclesPerRay + readCycles + 300;

    logic clk;
    logic globalreset;
    logic inValid;
    rayT inRay;
    logic inReady;
    logic rayWritten;
    logic [slotWidth-1:0] writtenSlot;
    logic [slotWidth-1:0] rdAddr;
    fieldT rdField;
    rayWordT rdData;

    logic [31:0] rngState;
    logic [31:0] expWords [numSlots][wordsPerRay]; // last ray sent to each slot
    logic slotUsed [numSlots];
    logic [slotWidth-1:0] sentSlots [$];
    logic [slotWidth-1:0] expectedSlot;
    logic sawFull;
    int acceptedCount;
    int writtenCount;
    int checkCount;
    int errorCount;
    int testCount;

    rayDispatch i_dut
    (
        .clk(clk),
        .globalreset(globalreset),
        .inValid(inValid),
        .inRay(inRay),
        .inReady(inReady),
        .rayWritten(rayWritten),
        .writtenSlot(writtenSlot),
        .rdAddr(rdAddr),
        .rdField(rdField),
        .rdData(rdData)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // packing rule written out as plain concatenations
    function automatic logic [31:0] expectedWord(input rayT r, input int field);
        logic [15:0] dx;
        logic [15:0] dy;
        logic [15:0] dz;
        dx = r.dir[47:32];
        dy = r.dir[31:16];
        dz = r.dir[15:0];
        case (field)
            1: return {4'h0, r.origX};
            2: return {4'h0, r.origY};
            3: return {4'h0, r.origZ};
            4: return {dy, dx};
            5: return {16'h0, dz};
            default: return 32'h0;
        endcase
    endfunction

    task automatic makeRandomRay(output rayT r);
        rngState = xorshift(rngState);
        r.slot = rngState[slotWidth-1:0];
        rngState = xorshift(rngState);
        r.origX = rngState[coordWidth-1:0];
        rngState = xorshift(rngState);
        r.origY = rngState[coordWidth-1:0];
        rngState = xorshift(rngState);
        r.origZ = rngState[coordWidth-1:0];
        rngState = xorshift(rngState);
        r.dir[47:16] = rngState;
        rngState = xorshift(rngState);
        r.dir[15:0] = rngState[15:0];
    endtask

    task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        assert (got === exp)
        else
        begin
            errorCount++;
            $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    // enters 1 ns after an edge and returns 1 ns after the edge that takes the ray
    task automatic offerRay(input rayT r);
        logic taken;
        taken = 1'b0;
        inRay = r;
        inValid = 1'b1;
        while (!taken)
        begin
            if (inReady)
            begin
                taken = 1'b1;
                sentSlots.push_back(r.slot);
                for (int f = 0; f < wordsPerRay; f++)
                begin
                    expWords[r.slot][f] = expectedWord(r, f + 1);
                end
                slotUsed[r.slot] = 1'b1;
                acceptedCount++;
            end
            else
            begin
                sawFull = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        inValid = 1'b0;
    endtask

    task automatic waitAllWritten();
        int limit;
        int cycles;
        limit = (acceptedCount - writtenCount + 2) * cyclesPerRay;
        cycles = 0;
        while ((writtenCount < acceptedCount) && (cycles < limit))
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        repeat (cyclesPerRay) @(posedge clk); // catch any extra pulse
        #1;
        checkValue("rayWritten count", 32'(writtenCount), 32'(acceptedCount));
    endtask

    task automatic readWord(input logic [slotWidth-1:0] slot, input int field,
                            output logic [31:0] value);
        rdAddr = slot;
        rdField = fieldT'(3'(field));
        @(posedge clk);
        #1;
        value = rdData;
    endtask

    task automatic checkSlot(input logic [slotWidth-1:0] slot);
        logic [31:0] got;
        for (int f = 0; f <= wordsPerRay; f++)
        begin
            readWord(slot, f, got);
            checkValue($sformatf("slot %0d field %0d", slot, f), got,
                       (f == 0) ? 32'h0 : expWords[slot][f-1]);
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testCount++;
        $display("test %0d %s finished with %0d errors", testCount, name,
                 errorCount - errorsBefore);
    endtask

    // each announced record must match the oldest ray still outstanding
    always @(negedge clk)
    begin
        if (!globalreset && rayWritten)
        begin
            writtenCount++;
            if (sentSlots.size() == 0)
            begin
                errorCount++;
                $display("rayWritten pulsed at %0t ns with no ray outstanding", $time);
            end
            else
            begin
                expectedSlot = sentSlots.pop_front();
                checkValue("writtenSlot", 32'(writtenSlot), 32'(expectedSlot));
            end
        end
    end

    initial
    begin
        rayT r;
        int errorsBefore;
        globalreset = 1'b1;
        inValid = 1'b0;
        inRay = '0;
        rdAddr = '0;
        rdField = fieldNone;
        rngState = 32'hfce0;
        sawFull = 1'b0;
        acceptedCount = 0;
        writtenCount = 0;
        checkCount = 0;
        errorCount = 0;
        testCount = 0;
        for (int s = 0; s < numSlots; s++)
        begin
            slotUsed[s] = 1'b0;
        end
        repeat (resetCycles) @(posedge clk);
        #1;
        globalreset = 1'b0;

        errorsBefore = errorCount;
        @(posedge clk);
        #1;
        checkValue("inReady after reset", 32'(inReady), 32'h1);
        checkValue("rayWritten after reset", 32'(rayWritten), 32'h0);
        finishTest("reset state", errorsBefore);

        errorsBefore = errorCount;
        makeRandomRay(r);
        offerRay(r);
        waitAllWritten();
        checkSlot(r.slot);
        finishTest("single ray", errorsBefore);

        errorsBefore = errorCount;
        sawFull = 1'b0;
        repeat (burstRays)
        begin
            makeRandomRay(r);
            offerRay(r);
        end
        checkCount++;
        assert (sawFull)
        else
        begin
            errorCount++;
            $display("inReady never fell while the burst filled the queue");
        end
        waitAllWritten();
        finishTest("burst with back-pressure", errorsBefore);

        errorsBefore = errorCount;
        for (int s = 0; s < numSlots; s++)
        begin
            if (slotUsed[s])
            begin
                checkSlot(slotWidth'(s));
            end
        end
        finishTest("read-back after burst", errorsBefore);

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

    initial
    begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", watchdogCycles);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/rayDispatch_properties.sv
`timescale 1ns/10ps
`default_nettype none

module writeProtocolChecker
    import rayPkg::*;
(
    input logic clk,
    input logic globalreset,
    input logic addrValid,
    input logic done,
    input rayWordT data,
    input logic [slotWidth-1:0] addr,
    input fieldT we
);

    logic addrValidQ;
    fieldT lastWe;
    fieldT expectedWe;
    logic newRequest;

    assign newRequest = addrValid & ~addrValidQ; // first cycle of a word write
    assign expectedWe = (lastWe == fieldDirZ) ? fieldOrigX : fieldT'(lastWe + 3'd1);

    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            addrValidQ <= 1'b0;
            lastWe <= fieldDirZ; // so the first word of the first ray must be origX
        end
        else
        begin
            addrValidQ <= addrValid;
            if (newRequest)
            begin
                lastWe <= we;
            end
        end
    end

    doneNeedsRequest: assert property (@(posedge clk) disable iff (globalreset)
        done |-> addrValid)
        else $error("done was high while addrValid was low");

    // request held with stable payload until the store answers
    requestHeld: assert property (@(posedge clk) disable iff (globalreset)
        addrValid && !done |=> addrValid && $stable(data) && $stable(addr) && $stable(we))
        else $error("addrValid dropped or its payload changed before done");

    // the store answers one cycle after a new request, for one cycle only
    donePulse: assert property (@(posedge clk) disable iff (globalreset)
        newRequest |=> done ##1 !done)
        else $error("done was not a single cycle pulse one cycle after addrValid rose");

    fieldOrder: assert property (@(posedge clk) disable iff (globalreset)
        newRequest |-> (we == expectedWe))
        else $error("word write field is out of order");

endmodule

bind rayGroupStore writeProtocolChecker i_protocolCheck
(
    .clk(clk),
    .globalreset(globalreset),
    .addrValid(wr.addrValid),
    .done(wr.done),
    .data(wr.data),
    .addr(wr.addr),
    .we(wr.we)
);

`default_nettype wire

// File: hw/rayDispatch.sv
`timescale 1ns/10ps
`default_nettype none

module rayDispatch
    import rayPkg::*;
(
    input logic clk,
    input logic globalreset,
    input logic inValid,
    input rayT inRay,
    output logic inReady,
    output logic rayWritten,
    output logic [slotWidth-1:0] writtenSlot,
    input logic [slotWidth-1:0] rdAddr,
    input fieldT rdField,
    output rayWordT rdData
);

    rayIf rayLink ();     // queue to sender
    rgWriteIf wordLink (); // sender to store

    rayQueue i_queue
    (
        .clk(clk),
        .globalreset(globalreset),
        .inValid(inValid),
        .inRay(inRay),
        .inReady(inReady),
        .out(rayLink.source)
    );

    raySender i_sender
    (
        .clk(clk),
        .globalreset(globalreset),
        .in(rayLink.sink),
        .wr(wordLink.writer)
    );

    rayGroupStore i_store
    (
        .clk(clk),
        .globalreset(globalreset),
        .wr(wordLink.target),
        .rayWritten(rayWritten),
        .writtenSlot(writtenSlot),
        .rdAddr(rdAddr),
        .rdField(rdField),
        .rdData(rdData)
    );

endmodule

`default_nettype wire

// File: hw/rayGroupStore.sv
`timescale 1ns/10ps
`default_nettype none

module rayGroupStore
    import rayPkg::*;
(
    input logic clk,
    input logic globalreset,
    rgWriteIf.target wr,
    output logic rayWritten,
    output logic [slotWidth-1:0] writtenSlot,
    input logic [slotWidth-1:0] rdAddr,
    input fieldT rdField,
    output rayWordT rdData
);

    rayWordT slotMem [numSlots][wordsPerRay];
    logic firstSeen;
    logic [2:0] wrIdx;
    logic [2:0] rdIdx;

    function automatic logic isDataField(input fieldT f);
        return (f >= fieldOrigX) && (f <= fieldDirZ);
    endfunction

    // a request counts once, on the cycle before done goes up
    assign firstSeen = wr.addrValid & ~wr.done;
    assign wrIdx = wr.we - 3'd1;
    assign rdIdx = rdField - 3'd1;

    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            wr.done <= 1'b0;
            rayWritten <= 1'b0;
            writtenSlot <= '0;
        end
        else
        begin
            wr.done <= firstSeen;
            // the record is complete once the dir z word has been acknowledged
            rayWritten <= wr.done && (wr.we == fieldDirZ);
            if (wr.done && (wr.we == fieldDirZ))
            begin
                writtenSlot <= wr.addr;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (firstSeen && isDataField(wr.we))
        begin
            slotMem[wr.addr][wrIdx] <= wr.data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (isDataField(rdField))
        begin
            rdData <= slotMem[rdAddr][rdIdx];
        end
        else
        begin
            rdData <= '0; // field 0 and unused codes read as zero
        end
    end

endmodule

`default_nettype wire

// File: hw/rayIf.sv
`timescale 1ns/10ps
`default_nettype none

// one ray per transfer, taken when valid and ready are both high
interface rayIf
    import rayPkg::*;
();

    logic valid;
    rayT ray;
    logic ready;

    modport source
    (
        output valid,
        output ray,
        input ready
    );

    modport sink
    (
        input valid,
        input ray,
        output ready
    );

endinterface

`default_nettype wire

// File: hw/rayPkg.sv
`default_nettype none

package rayPkg;

    localparam int coordWidth = 28;
    localparam int dirWidth = 16;
    localparam int slotWidth = 4;
    localparam int numSlots = 1 << slotWidth;
    localparam int queueDepth = 4;
    localparam int queuePtrWidth = $clog2(queueDepth);
    localparam int wordsPerRay = 5;

    // sender FSM encodings
    localparam logic [1:0] senderIdle = 2'd0;
    localparam logic [1:0] senderWait = 2'd1; // addrValid up, waiting for done
    localparam logic [1:0] senderGap = 2'd2;

    typedef struct packed {
        logic [slotWidth-1:0] slot;
        logic [coordWidth-1:0] origX;
        logic [coordWidth-1:0] origY;
        logic [coordWidth-1:0] origZ;
        logic [3*dirWidth-1:0] dir; // x on top, then y, then z
    } rayT;

    // one stored word, read either as a coordinate or as two direction parts
    typedef union packed {
        struct packed {
            logic [31-coordWidth:0] pad;
            logic [coordWidth-1:0] value;
        } coord;
        struct packed {
            logic [dirWidth-1:0] hi;
            logic [dirWidth-1:0] lo;
        } dirPair;
    } rayWordT;

    typedef enum logic [2:0] {
        fieldNone = 3'd0,
        fieldOrigX = 3'd1,
        fieldOrigY = 3'd2,
        fieldOrigZ = 3'd3,
        fieldDirXY = 3'd4,
        fieldDirZ = 3'd5
    } fieldT;

endpackage

`default_nettype wire

// File: hw/rayQueue.sv
`timescale 1ns/10ps
`default_nettype none

module rayQueue
    import rayPkg::*;
(
    input logic clk,
    input logic globalreset,
    input logic inValid,
    input rayT inRay,
    output logic inReady,
    rayIf.source out
);

    localparam logic [queuePtrWidth:0] fullCount = (queuePtrWidth + 1)'(queueDepth);

    rayT entries [queueDepth];
    logic [queuePtrWidth-1:0] wrPtr;
    logic [queuePtrWidth-1:0] rdPtr;
    logic [queuePtrWidth:0] count;
    logic push;
    logic pop;

    function automatic logic [queuePtrWidth-1:0] nextPtr(input logic [queuePtrWidth-1:0] ptr);
        if (ptr == queuePtrWidth'(queueDepth - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign inReady = (count != fullCount);
    assign push = inValid & inReady;
    assign pop = out.valid & out.ready;

    // the oldest ray sits on the output whenever something is queued
    assign out.valid = (count != '0);
    assign out.ray = entries[rdPtr];

    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
            begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop)
            begin
                rdPtr <= nextPtr(rdPtr);
            end
            if (push && !pop)
            begin
                count <= count + 1'b1;
            end
            else if (pop && !push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            entries[wrPtr] <= inRay;
        end
    end

endmodule

`default_nettype wire

// File: hw/raySender.sv
`timescale 1ns/10ps
`default_nettype none

module raySender
    import rayPkg::*;
(
    input logic clk,
    input logic globalreset,
    rayIf.sink in,
    rgWriteIf.writer wr
);

    logic [1:0] state;
    rayT rayReg;
    fieldT nextField;
    logic accept;

    // builds one of the five words through the matching union view
    function automatic rayWordT packWord(input rayT r, input fieldT f);
        rayWordT w;
        w = '0;
        case (f)
            fieldOrigX:
            begin
                w.coord.value = r.origX;
            end
            fieldOrigY:
            begin
                w.coord.value = r.origY;
            end
            fieldOrigZ:
            begin
                w.coord.value = r.origZ;
            end
            fieldDirXY:
            begin
                w.dirPair.hi = r.dir[dirWidth +: dirWidth];   // y
                w.dirPair.lo = r.dir[2*dirWidth +: dirWidth]; // x
            end
            fieldDirZ:
            begin
                w.dirPair.lo = r.dir[0 +: dirWidth];
            end
            default:
            begin
                w = '0;
            end
        endcase
        return w;
    endfunction

    assign in.ready = (state == senderIdle);
    assign accept = in.valid & in.ready;
    assign nextField = fieldT'(wr.we + 3'd1);

    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            state <= senderIdle;
            wr.addrValid <= 1'b0;
            wr.we <= fieldNone;
        end
        else
        begin
            case (state)
                senderIdle:
                begin
                    if (accept)
                    begin
                        wr.we <= fieldOrigX;
                        wr.addrValid <= 1'b1;
                        state <= senderWait;
                    end
                end
                senderWait:
                begin
                    if (wr.done)
                    begin
                        wr.addrValid <= 1'b0;
                        if (wr.we == fieldDirZ)
                        begin
                            // last word taken, so the next ray can come in right away
                            wr.we <= fieldNone;
                            state <= senderIdle;
                        end
                        else
                        begin
                            state <= senderGap;
                        end
                    end
                end
                senderGap:
                begin
                    wr.we <= nextField;
                    wr.addrValid <= 1'b1;
                    state <= senderWait;
                end
                default:
                begin
                    state <= senderIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            rayReg <= in.ray;
            wr.addr <= in.ray.slot;
            wr.data <= packWord(in.ray, fieldOrigX); // first word straight from the input
        end
        else if (state == senderGap)
        begin
            wr.data <= packWord(rayReg, nextField);
        end
    end

endmodule

`default_nettype wire

// File: hw/rgWriteIf.sv
`timescale 1ns/10ps
`default_nettype none

interface rgWriteIf
    import rayPkg::*;
();

    rayWordT data;
    logic [slotWidth-1:0] addr;
    fieldT we;
    logic addrValid; // held with data, addr and we until done
    logic done;      // single cycle answer from the store

    modport writer
    (
        output data,
        output addr,
        output we,
        output addrValid,
        input done
    );

    modport target
    (
        input data,
        input addr,
        input we,
        input addrValid,
        output done
    );

endinterface

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the ray dispatch testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module rayDispatchTb \
    || { echo "build failed"; exit 1; }

out=$(./obj_dir/VrayDispatchTb)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "Everything OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: src.f
hw/rayPkg.sv
hw/rayIf.sv
hw/rgWriteIf.sv
hw/rayQueue.sv
hw/raySender.sv
hw/rayGroupStore.sv
hw/rayDispatch.sv
dv/rayDispatch_properties.sv
dv/rayDispatchTb.sv
